//--- design/ether_pkg.sv
// Shared constants, host address map and stage structs of the RMII Ethernet MAC, wildcard-imported
`default_nettype none

package ether_pkg;

    // Frame buffer geometry
    localparam int FRAME_DEPTH  = 1522;             // MTU plus 22
    localparam int FRAME_ADDR_W = 11;
    localparam int HOST_ADDR_W  = 14;

    // Host address map, decoded from the top address bits
    localparam logic [2:0] REGION_REGS = 3'b011;    // addr[13:11]
    localparam logic [1:0] REGION_SEND = 2'b10;     // addr[13:12]
    localparam logic [1:0] REGION_RECV = 2'b11;     // addr[13:12]

    // Register offsets within the register region
    localparam int                   REG_OFS_W     = 5;
    localparam logic [REG_OFS_W-1:0] REG_SEND_BUSY = 5'h00;
    localparam logic [REG_OFS_W-1:0] REG_SEND_LEN  = 5'h04;
    localparam logic [REG_OFS_W-1:0] REG_CMD_SEND  = 5'h08;  // Bit 0 starts a send
    localparam logic [REG_OFS_W-1:0] REG_RECV_LEN  = 5'h0c;
    localparam logic [REG_OFS_W-1:0] REG_RECV_DONE = 5'h10;  // Nonzero releases the frame

    // Line coding
    localparam int         PREAMBLE_BYTES = 7;
    localparam logic [7:0] PREAMBLE_BYTE  = 8'h55;
    localparam logic [7:0] SFD_BYTE       = 8'hd5;
    localparam logic [1:0] SFD_DIBIT      = 2'b11;  // Closing dibit of the SFD

    // Collision handling
    localparam int BACKOFF_CYCLES = 1024;
    localparam int BACKOFF_W      = $clog2(BACKOFF_CYCLES);

    // Host request, taken whenever valid
    typedef struct packed {
        logic                   valid;
        logic                   we;
        logic [HOST_ADDR_W-1:0] addr;
        logic [31:0]            wdata;
    } host_req_t;

    // Read response, two cycles after the request
    typedef struct packed {
        logic        valid;
        logic [31:0] rdata;
    } host_rsp_t;

    // One byte between receive stages
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } byte_beat_t;

    // Frame buffer write port
    typedef struct packed {
        logic                    en;
        logic [FRAME_ADDR_W-1:0] addr;
        logic [7:0]              data;
    } ram_wr_t;

endpackage

`default_nettype wire

//--- design/frame_ram.sv
// Byte-wide simple dual-port frame buffer with registered read, one per direction of the MAC
`timescale 1ns/1ps
`default_nettype none

module frame_ram
    import ether_pkg::*;
(
    input  wire                     CLK,
    input  wire ram_wr_t            wr,
    input  wire [FRAME_ADDR_W-1:0]  rd_addr,
    output logic [7:0]              rd_data
);

    logic [7:0] mem [0:FRAME_DEPTH-1];

    always_ff @(posedge CLK) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // Data appears one cycle after the address
    always_ff @(posedge CLK) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

//--- design/ether_regs.sv
// Host port of the MAC: address decode, control registers, command pulses and read response
`timescale 1ns/1ps
`default_nettype none

module ether_regs
    import ether_pkg::*;
(
    input  wire                     CLK,
    input  wire                     RST_X,
    input  wire host_req_t          req,
    output host_rsp_t               rsp,
    output ram_wr_t                 send_wr,
    output logic                    send_start,
    output logic [FRAME_ADDR_W-1:0] send_len,
    input  wire                     tx_busy,
    output logic                    recv_done,
    input  wire [FRAME_ADDR_W-1:0]  recv_len,
    output logic [FRAME_ADDR_W-1:0] recv_rd_addr,
    input  wire [7:0]               recv_rd_data
);

    logic                 is_regs;
    logic                 is_send;
    logic                 is_recv;
    logic                 reg_hit;
    logic [REG_OFS_W-1:0] reg_ofs;
    logic                 wr_req;
    logic                 rd_req;
    logic [31:0]          reg_rdata;
    logic                 rd_vld_q;
    logic                 rd_ram_q;
    logic [31:0]          reg_rdata_q;
    logic                 rsp_vld_q;
    logic [31:0]          rsp_data_q;

    assign is_regs = req.addr[HOST_ADDR_W-1 -: 3] == REGION_REGS;
    assign is_send = req.addr[HOST_ADDR_W-1 -: 2] == REGION_SEND;
    assign is_recv = req.addr[HOST_ADDR_W-1 -: 2] == REGION_RECV;
    assign reg_ofs = req.addr[REG_OFS_W-1:0];
    assign reg_hit = is_regs && (req.addr[FRAME_ADDR_W-1:REG_OFS_W] == '0);  // No aliasing
    assign wr_req  = req.valid && req.we;
    assign rd_req  = req.valid && !req.we;

    // Host writes land in the send buffer directly
    assign send_wr = '{en:   wr_req && is_send,
                       addr: req.addr[FRAME_ADDR_W-1:0],
                       data: req.wdata[7:0]};

    assign recv_rd_addr = req.addr[FRAME_ADDR_W-1:0];  // RAM starts its read with the request

    always_comb begin
        reg_rdata = '0;
        if (reg_hit) begin
            case (reg_ofs)
                REG_SEND_BUSY: reg_rdata = {31'b0, tx_busy};
                REG_SEND_LEN:  reg_rdata = {{(32-FRAME_ADDR_W){1'b0}}, send_len};
                REG_RECV_LEN:  reg_rdata = {{(32-FRAME_ADDR_W){1'b0}}, recv_len};
                default:       reg_rdata = '0;       // Command offsets are write-only
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (!RST_X) begin
            send_len   <= '0;
            send_start <= 1'b0;
            recv_done  <= 1'b0;
        end else begin
            send_start <= wr_req && reg_hit && (reg_ofs == REG_CMD_SEND) && req.wdata[0];
            recv_done  <= wr_req && reg_hit && (reg_ofs == REG_RECV_DONE) && (req.wdata != '0);
            if (wr_req && reg_hit && (reg_ofs == REG_SEND_LEN)) begin
                send_len <= req.wdata[FRAME_ADDR_W-1:0];
            end
        end
    end

    // Two-stage response, registers held back one stage to line up with the RAM
    always_ff @(posedge CLK) begin
        if (!RST_X) begin
            rd_vld_q  <= 1'b0;
            rsp_vld_q <= 1'b0;
        end else begin
            rd_vld_q  <= rd_req;
            rsp_vld_q <= rd_vld_q;
        end
    end

    always_ff @(posedge CLK) begin
        rd_ram_q    <= rd_req && is_recv;
        reg_rdata_q <= reg_rdata;
        rsp_data_q  <= rd_ram_q ? {24'b0, recv_rd_data} : reg_rdata_q;
    end

    assign rsp = '{valid: rsp_vld_q, rdata: rsp_data_q};

endmodule

`default_nettype wire

//--- design/rmii_tx.sv
// RMII transmitter: preamble and SFD insertion, dibit serializer and collision back-off
`timescale 1ns/1ps
`default_nettype none

module rmii_tx
    import ether_pkg::*;
(
    input  wire                     CLK,
    input  wire                     RST_X,
    input  wire                     send_start,
    input  wire [FRAME_ADDR_W-1:0]  send_len,
    output logic [FRAME_ADDR_W-1:0] buf_addr,
    input  wire [7:0]               buf_data,
    input  wire                     crs_dv,
    output logic [1:0]              txd,
    output logic                    tx_en,
    output logic                    tx_busy
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SEND,
        ST_BACKOFF
    } tx_state_e;

    tx_state_e               state;
    logic [FRAME_ADDR_W-1:0] len;
    logic [FRAME_ADDR_W-1:0] byte_idx;
    logic [FRAME_ADDR_W-1:0] next_idx;
    logic [1:0]              dibit_cnt;
    logic [7:0]              shreg;
    logic [7:0]              next_byte;
    logic                    last_byte;
    logic [BACKOFF_W-1:0]    backoff_cnt;

    assign next_idx  = byte_idx + 1'b1;
    assign buf_addr  = next_idx;            // Next byte is read while this one shifts out
    assign last_byte = next_idx >= len;
    assign tx_busy   = state != ST_IDLE;
    assign txd       = tx_en ? shreg[1:0] : 2'b00;

    // Bytes 0 to 7 are replaced on the wire
    always_comb begin
        if (next_idx < FRAME_ADDR_W'(PREAMBLE_BYTES)) begin
            next_byte = PREAMBLE_BYTE;
        end else if (next_idx == FRAME_ADDR_W'(PREAMBLE_BYTES)) begin
            next_byte = SFD_BYTE;
        end else begin
            next_byte = buf_data;
        end
    end

    always_ff @(posedge CLK) begin
        if (!RST_X) begin
            state       <= ST_IDLE;
            tx_en       <= 1'b0;
            len         <= '0;
            byte_idx    <= '0;
            dibit_cnt   <= '0;
            backoff_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (send_start) begin
                        state     <= ST_SEND;
                        len       <= send_len;
                        tx_en     <= 1'b1;
                        byte_idx  <= '0;
                        dibit_cnt <= '0;
                    end
                end
                ST_SEND: begin
                    if (crs_dv) begin                  // Collision
                        state       <= ST_BACKOFF;
                        tx_en       <= 1'b0;
                        backoff_cnt <= '0;
                    end else if (dibit_cnt == 2'd3) begin
                        dibit_cnt <= '0;
                        byte_idx  <= next_idx;
                        if (last_byte) begin
                            state <= ST_IDLE;
                            tx_en <= 1'b0;
                        end
                    end else begin
                        dibit_cnt <= dibit_cnt + 1'b1;
                    end
                end
                ST_BACKOFF: begin
                    backoff_cnt <= backoff_cnt + 1'b1;
                    if (backoff_cnt == BACKOFF_W'(BACKOFF_CYCLES - 1)) begin
                        state     <= ST_SEND;          // Resend from byte 0
                        tx_en     <= 1'b1;
                        byte_idx  <= '0;
                        dibit_cnt <= '0;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                    tx_en <= 1'b0;
                end
            endcase
        end
    end

    // Low dibit first; first byte of every attempt is preamble
    always_ff @(posedge CLK) begin
        if (state != ST_SEND) begin
            shreg <= PREAMBLE_BYTE;
        end else if (dibit_cnt == 2'd3) begin
            shreg <= next_byte;
        end else begin
            shreg <= shreg >> 2;
        end
    end

endmodule

`default_nettype wire

//--- design/rmii_rx.sv
// RMII receiver: hunts for the end of the SFD and assembles dibits into byte beats
`timescale 1ns/1ps
`default_nettype none

module rmii_rx
    import ether_pkg::*;
(
    input  wire         CLK,
    input  wire         RST_X,
    input  wire [1:0]   rxd,
    input  wire         crs_dv,
    output byte_beat_t  beat,
    output logic        frame_end
);

    typedef enum logic {
        ST_HUNT,
        ST_DATA
    } rx_state_e;

    rx_state_e  state;
    logic [1:0] dibit_cnt;
    logic [7:0] shreg;
    logic       beat_vld;

    // Shift register holds the full byte in the cycle the beat is valid
    assign beat = '{valid: beat_vld, data: shreg};

    always_ff @(posedge CLK) begin
        if (!RST_X) begin
            state     <= ST_HUNT;
            dibit_cnt <= '0;
            beat_vld  <= 1'b0;
            frame_end <= 1'b0;
        end else begin
            beat_vld  <= 1'b0;
            frame_end <= 1'b0;
            case (state)
                ST_HUNT: begin
                    if (crs_dv && (rxd == SFD_DIBIT)) begin
                        state     <= ST_DATA;
                        dibit_cnt <= '0;
                    end
                end
                ST_DATA: begin
                    if (crs_dv) begin
                        dibit_cnt <= dibit_cnt + 1'b1;
                        beat_vld  <= dibit_cnt == 2'd3;
                    end else begin
                        state     <= ST_HUNT;      // Partial byte is dropped
                        frame_end <= 1'b1;
                    end
                end
                default: state <= ST_HUNT;
            endcase
        end
    end

    // Low bits arrive first, so shift in from the top
    always_ff @(posedge CLK) begin
        if ((state == ST_DATA) && crs_dv) begin
            shreg <= {rxd, shreg[7:2]};
        end
    end

endmodule

`default_nettype wire

//--- design/rx_frame_writer.sv
// Stores received bytes in the receive buffer and holds the frame pending until the host is done
`timescale 1ns/1ps
`default_nettype none

module rx_frame_writer
    import ether_pkg::*;
(
    input  wire                     CLK,
    input  wire                     RST_X,
    input  wire byte_beat_t         beat,
    input  wire                     frame_end,
    output ram_wr_t                 recv_wr,
    output logic [FRAME_ADDR_W-1:0] recv_len,
    output logic                    recv_pending,
    input  wire                     recv_done
);

    logic [FRAME_ADDR_W-1:0] wr_addr;
    logic                    dropping;
    logic                    take;

    // A frame that starts while pending is dropped as a whole
    assign take    = beat.valid && !recv_pending && !dropping;
    assign recv_wr = '{en: take, addr: wr_addr, data: beat.data};

    always_ff @(posedge CLK) begin
        if (!RST_X) begin
            wr_addr      <= '0;
            recv_len     <= '0;
            recv_pending <= 1'b0;
            dropping     <= 1'b0;
        end else begin
            if (frame_end) begin
                dropping <= 1'b0;
            end else if (beat.valid && recv_pending) begin
                dropping <= 1'b1;
            end

            if (recv_pending) begin
                if (recv_done) begin
                    recv_pending <= 1'b0;          // Frame released
                    wr_addr      <= '0;
                end
            end else if (frame_end && !dropping) begin
                recv_len     <= wr_addr;           // Byte count
                recv_pending <= 1'b1;
            end else if (take) begin
                wr_addr <= wr_addr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/ether_mac.sv
// Top level of the RMII Ethernet MAC, connecting host registers, buffers, transmitter and receiver
`timescale 1ns/1ps
`default_nettype none

module ether_mac
    import ether_pkg::*;
(
    input  wire         CLK,
    input  wire         RST_X,
    input  wire host_req_t req,
    output host_rsp_t   rsp,
    output logic [1:0]  txd,
    output logic        tx_en,
    input  wire [1:0]   rxd,
    input  wire         crs_dv,
    output logic        recv_pending
);

    // Transmit path
    ram_wr_t                 send_wr;
    logic                    send_start;
    logic [FRAME_ADDR_W-1:0] send_len;
    logic [FRAME_ADDR_W-1:0] send_rd_addr;
    logic [7:0]              send_rd_data;
    logic                    tx_busy;

    // Receive path
    byte_beat_t              rx_beat;
    logic                    frame_end;
    ram_wr_t                 recv_wr;
    logic [FRAME_ADDR_W-1:0] recv_len;
    logic [FRAME_ADDR_W-1:0] recv_rd_addr;
    logic [7:0]              recv_rd_data;
    logic                    recv_done;

    ether_regs u_regs (
        .CLK          (CLK),
        .RST_X        (RST_X),
        .req          (req),
        .rsp          (rsp),
        .send_wr      (send_wr),
        .send_start   (send_start),
        .send_len     (send_len),
        .tx_busy      (tx_busy),
        .recv_done    (recv_done),
        .recv_len     (recv_len),
        .recv_rd_addr (recv_rd_addr),
        .recv_rd_data (recv_rd_data)
    );

    frame_ram u_send_ram (
        .CLK     (CLK),
        .wr      (send_wr),
        .rd_addr (send_rd_addr),
        .rd_data (send_rd_data)
    );

    rmii_tx u_tx (
        .CLK        (CLK),
        .RST_X      (RST_X),
        .send_start (send_start),
        .send_len   (send_len),
        .buf_addr   (send_rd_addr),
        .buf_data   (send_rd_data),
        .crs_dv     (crs_dv),
        .txd        (txd),
        .tx_en      (tx_en),
        .tx_busy    (tx_busy)
    );

    rmii_rx u_rx (
        .CLK       (CLK),
        .RST_X     (RST_X),
        .rxd       (rxd),
        .crs_dv    (crs_dv),
        .beat      (rx_beat),
        .frame_end (frame_end)
    );

    rx_frame_writer u_rx_writer (
        .CLK          (CLK),
        .RST_X        (RST_X),
        .beat         (rx_beat),
        .frame_end    (frame_end),
        .recv_wr      (recv_wr),
        .recv_len     (recv_len),
        .recv_pending (recv_pending),
        .recv_done    (recv_done)
    );

    frame_ram u_recv_ram (
        .CLK     (CLK),
        .wr      (recv_wr),
        .rd_addr (recv_rd_addr),
        .rd_data (recv_rd_data)
    );

endmodule

`default_nettype wire

//--- verification/ether_mac_assert.sv
// Protocol assertions on the MAC's top-level signals, attached to every ether_mac by bind
`timescale 1ns/1ps
`default_nettype none

module ether_mac_assert (
    input wire       CLK,
    input wire       RST_X,
    input wire [1:0] txd,
    input wire       tx_en,
    input wire       tx_busy,
    input wire       recv_pending,
    input wire       recv_done
);

    int fail_cnt = 0;

    a_txd_idle: assert property (@(posedge CLK) disable iff (!RST_X)
        !tx_en |-> txd == 2'b00)
    else begin
        fail_cnt++;
        $error("txd is not zero while tx_en is low");
    end

    // Line is only driven inside a send
    a_tx_en_busy: assert property (@(posedge CLK) disable iff (!RST_X)
        !tx_busy |-> !tx_en)
    else begin
        fail_cnt++;
        $error("tx_en is high while tx_busy is low");
    end

    a_pending_hold: assert property (@(posedge CLK) disable iff (!RST_X)
        (recv_pending && !recv_done) |=> recv_pending)
    else begin
        fail_cnt++;
        $error("recv_pending fell without recv_done");
    end

endmodule

bind ether_mac ether_mac_assert u_assert (
    .CLK          (CLK),
    .RST_X        (RST_X),
    .txd          (txd),
    .tx_en        (tx_en),
    .tx_busy      (tx_busy),
    .recv_pending (recv_pending),
    .recv_done    (recv_done)
);

`default_nettype wire

//--- verification/tb_ether_mac.sv
// Testbench for the RMII Ethernet MAC: host register and buffer access, send, receive and collision
`timescale 1ns/1ps
`default_nettype none

module tb_ether_mac
    import ether_pkg::*;
;

    localparam int NUM_TX  = 6;     // Random transmit frames
    localparam int MAX_LEN = 64;    // Longest random frame

    logic       CLK;
    logic       RST_X;
    host_req_t  req;
    host_rsp_t  rsp;
    logic [1:0] txd;
    logic       tx_en;
    logic [1:0] rxd;
    logic       crs_dv;
    logic       recv_pending;

    int errors      = 0;
    int checks      = 0;
    int tests       = 0;
    int tests_fail  = 0;
    int test_errors = 0;

    logic [7:0] tx_frame [0:FRAME_DEPTH-1];     // Send buffer model
    logic [7:0] rx_frame [0:FRAME_DEPTH-1];     // Receive buffer model
    int         rx_len = 0;

    // Monitor state
    logic [7:0] cap_buf [0:FRAME_DEPTH-1];
    int         cap_len   = 0;
    int         run_len   = 0;
    int         tx_starts = 0;
    logic [1:0] dib_cnt   = 2'd0;
    logic [7:0] cap_byte  = 8'h00;
    logic       tx_en_q   = 1'b0;

    ether_mac i_dut (
        .CLK          (CLK),
        .RST_X        (RST_X),
        .req          (req),
        .rsp          (rsp),
        .txd          (txd),
        .tx_en        (tx_en),
        .rxd          (rxd),
        .crs_dv       (crs_dv),
        .recv_pending (recv_pending)
    );

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    // Watchdog sized from the test lengths and the back-off wait
    initial begin
        int limit;
        limit = (NUM_TX + 8) * (16 * MAX_LEN + 100) + 2 * BACKOFF_CYCLES + 1000;
        repeat (limit) @(posedge CLK);
        $display("Watchdog: run did not finish within %0d cycles", limit);
        $display("SOME TESTS FAILED");
        $finish;
    end

    // Captures txd bytes, low dibit first
    always @(negedge CLK) begin
        if (tx_en) begin
            if (!tx_en_q) begin
                cap_len = 0;
                run_len = 0;
                dib_cnt = 2'd0;
                tx_starts++;
            end
            cap_byte = {txd, cap_byte[7:2]};
            run_len++;
            if (dib_cnt == 2'd3) begin
                cap_buf[cap_len] = cap_byte;
                cap_len++;
            end
            dib_cnt++;
        end
        tx_en_q = tx_en;
    end

    function automatic logic [HOST_ADDR_W-1:0] reg_addr(input logic [REG_OFS_W-1:0] ofs);
        return {REGION_REGS, 6'b0, ofs};
    endfunction

    function automatic logic [HOST_ADDR_W-1:0] send_addr(input int idx);
        return {REGION_SEND, 1'b0, idx[FRAME_ADDR_W-1:0]};
    endfunction

    function automatic logic [HOST_ADDR_W-1:0] recv_addr(input int idx);
        return {REGION_RECV, 1'b0, idx[FRAME_ADDR_W-1:0]};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s is 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic start_test();
        test_errors = errors;
        tests++;
    endtask

    task automatic report_test(input string name);
        if (errors == test_errors) begin
            $display("Test %0d %s: ok", tests, name);
        end else begin
            tests_fail++;
            $display("Test %0d %s: failed with %0d errors", tests, name, errors - test_errors);
        end
    endtask

    // All host tasks start and end on a falling edge
    task automatic host_write(input logic [HOST_ADDR_W-1:0] addr, input logic [31:0] data);
        req.valid = 1'b1;
        req.we    = 1'b1;
        req.addr  = addr;
        req.wdata = data;
        @(negedge CLK);
        req = '0;
    endtask

    task automatic host_read(input logic [HOST_ADDR_W-1:0] addr, output logic [31:0] data);
        req.valid = 1'b1;
        req.we    = 1'b0;
        req.addr  = addr;
        req.wdata = $urandom;
        @(negedge CLK);
        req = '0;
        check_value("rsp.valid one cycle after read", rsp.valid, 1'b0);
        @(negedge CLK);
        check_value("rsp.valid two cycles after read", rsp.valid, 1'b1);
        data = rsp.rdata;
    endtask

    task automatic wait_tx_en(input logic level, input int limit);
        int n;
        n = 0;
        while (tx_en !== level && n < limit) begin
            @(negedge CLK);
            n++;
        end
        if (tx_en !== level) begin
            errors++;
            $display("Timeout: tx_en did not go to %0d within %0d cycles", level, limit);
        end
    endtask

    task automatic wait_pending(input logic level, input int limit);
        int n;
        n = 0;
        while (recv_pending !== level && n < limit) begin
            @(negedge CLK);
            n++;
        end
        if (recv_pending !== level) begin
            errors++;
            $display("Timeout: recv_pending did not go to %0d within %0d cycles", level, limit);
        end
    endtask

    task automatic load_and_send(input int len);
        logic [31:0] w;
        for (int i = 0; i < len; i++) begin
            w = $urandom;
            tx_frame[i] = w[7:0];
            host_write(send_addr(i), w);
        end
        host_write(reg_addr(REG_SEND_LEN), len);
        host_write(reg_addr(REG_CMD_SEND), 32'h1);
    endtask

    task automatic check_tx_frame(input int len);
        logic [7:0] exp;
        check_value("tx frame length", cap_len, len);
        check_value("tx_en high cycles", run_len, 4 * len);
        for (int i = 0; i < len && i < cap_len; i++) begin
            if (i < PREAMBLE_BYTES) begin
                exp = PREAMBLE_BYTE;
            end else if (i == PREAMBLE_BYTES) begin
                exp = SFD_BYTE;
            end else begin
                exp = tx_frame[i];
            end
            check_value($sformatf("txd byte %0d", i), cap_buf[i], exp);
        end
    endtask

    // Preamble, closing SFD dibit, then bytes with the low dibit first
    task automatic drive_rx(input int n, input bit store);
        logic [7:0] b;
        crs_dv = 1'b1;
        rxd    = 2'b01;
        repeat (31) @(negedge CLK);
        rxd = SFD_DIBIT;
        @(negedge CLK);
        for (int i = 0; i < n; i++) begin
            b = $urandom;
            if (store) begin
                rx_frame[i] = b;
            end
            for (int d = 0; d < 4; d++) begin
                rxd = b[2*d +: 2];
                @(negedge CLK);
            end
        end
        if (store) begin
            rx_len = n;
        end
        crs_dv = 1'b0;
        rxd    = 2'b00;
    endtask

    task automatic check_rx_buffer();
        logic [31:0] d;
        host_read(reg_addr(REG_RECV_LEN), d);
        check_value("REG_RECV_LEN", d, rx_len);
        for (int i = 0; i < rx_len; i++) begin
            host_read(recv_addr(i), d);
            check_value($sformatf("receive buffer byte %0d", i), d, {24'b0, rx_frame[i]});
        end
    endtask

    task automatic test_registers();
        logic [31:0] v;
        logic [31:0] d;
        start_test();
        check_value("tx_en after reset", tx_en, 1'b0);
        check_value("txd after reset", txd, 2'b00);
        check_value("recv_pending after reset", recv_pending, 1'b0);
        check_value("rsp.valid after reset", rsp.valid, 1'b0);
        repeat (4) begin
            v = $urandom;
            host_write(reg_addr(REG_SEND_LEN), v);
            host_read(reg_addr(REG_SEND_LEN), d);
            check_value("REG_SEND_LEN", d, v & 32'h7ff);
        end
        host_read(reg_addr(REG_CMD_SEND), d);
        check_value("REG_CMD_SEND read", d, 32'h0);
        host_read(reg_addr(5'h14), d);
        check_value("unmapped offset 0x14", d, 32'h0);
        host_read({REGION_REGS, 6'h01, REG_SEND_LEN}, d);    // Alias of REG_SEND_LEN
        check_value("unmapped offset 0x24", d, 32'h0);
        host_read(send_addr(3), d);
        check_value("send region read", d, 32'h0);
        host_read(14'h0100, d);
        check_value("unmapped region", d, 32'h0);
        report_test("register access");
    endtask

    task automatic test_transmit();
        int len;
        start_test();
        for (int f = 0; f < NUM_TX; f++) begin
            len = 9 + $urandom % (MAX_LEN - 8);
            load_and_send(len);
            wait_tx_en(1'b1, 10);
            wait_tx_en(1'b0, 4 * MAX_LEN + 10);
            @(negedge CLK);
            check_tx_frame(len);
        end
        report_test("transmit");
    endtask

    task automatic test_busy();
        int len;
        int starts;
        logic [31:0] d;
        start_test();
        len = 9 + $urandom % (MAX_LEN - 8);
        starts = tx_starts;
        load_and_send(len);
        wait_tx_en(1'b1, 10);
        host_read(reg_addr(REG_SEND_BUSY), d);
        check_value("REG_SEND_BUSY during send", d, 32'h1);
        host_write(reg_addr(REG_CMD_SEND), 32'h1);           // Ignored while busy
        wait_tx_en(1'b0, 4 * MAX_LEN + 10);
        host_read(reg_addr(REG_SEND_BUSY), d);
        check_value("REG_SEND_BUSY after send", d, 32'h0);
        repeat (20) @(negedge CLK);
        check_value("frames started", tx_starts, starts + 1);
        check_tx_frame(len);
        report_test("busy");
    endtask

    task automatic test_receive();
        start_test();
        drive_rx(1 + $urandom % MAX_LEN, 1'b1);
        wait_pending(1'b1, 10);
        check_rx_buffer();
        report_test("receive");
    endtask

    task automatic test_drop();
        start_test();
        drive_rx(1 + $urandom % MAX_LEN, 1'b0);
        repeat (4) @(negedge CLK);
        check_value("recv_pending while dropping", recv_pending, 1'b1);
        check_rx_buffer();
        host_write(reg_addr(REG_RECV_DONE), $urandom | 32'h1);
        wait_pending(1'b0, 5);
        drive_rx(1 + $urandom % MAX_LEN, 1'b1);
        wait_pending(1'b1, 10);
        check_rx_buffer();
        report_test("drop while pending");
    endtask

    task automatic test_collision();
        int len;
        start_test();
        len = 9 + $urandom % (MAX_LEN - 8);
        load_and_send(len);
        wait_tx_en(1'b1, 10);
        repeat (8 + $urandom % (4 * len - 16)) @(negedge CLK);
        crs_dv = 1'b1;                                       // Carrier with rxd idle
        rxd    = 2'b00;
        @(negedge CLK);
        crs_dv = 1'b0;
        check_value("tx_en after collision", tx_en, 1'b0);
        wait_tx_en(1'b1, BACKOFF_CYCLES + 10);
        wait_tx_en(1'b0, 4 * MAX_LEN + 10);
        @(negedge CLK);
        check_tx_frame(len);
        report_test("collision");
    endtask

    initial begin
        RST_X  = 1'b0;
        req    = '0;
        rxd    = 2'b00;
        crs_dv = 1'b0;
        void'($urandom(33654));
        repeat (4) @(negedge CLK);
        RST_X = 1'b1;
        @(negedge CLK);
        test_registers();
        test_transmit();
        test_busy();
        test_receive();
        test_drop();
        test_collision();
        errors = errors + i_dut.u_assert.fail_cnt;
        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests, tests_fail, checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- ether_mac.f
design/ether_pkg.sv
design/frame_ram.sv
design/ether_regs.sv
design/rmii_tx.sv
design/rmii_rx.sv
design/rx_frame_writer.sv
design/ether_mac.sv
verification/ether_mac_assert.sv
verification/tb_ether_mac.sv
